//--- verilog/h2c_cfg_settings.svh
`ifndef H2C_CFG_SETTINGS_SVH
`define H2C_CFG_SETTINGS_SVH

// Host bus and engine widths
`define H2C_CFG_ADDR_W     16
`define H2C_CFG_DATA_W     32
`define H2C_CFG_PTR_W      16
`define H2C_CFG_WB_ADDR_W  48

// Descriptor info word fields
`define H2C_CFG_DESC_TYPE       1'b0
`define H2C_CFG_DESC_RAM_DEPTH  16'd64

// Range bases, upper address byte of each 256-byte window
`define H2C_CFG_PAGE_DESC  8'h01
`define H2C_CFG_PAGE_DM    8'h02
`define H2C_CFG_PAGE_WB    8'h03

// Read patterns for unmapped addresses and unknown offsets
`define H2C_CFG_BAD_OOR   32'hbaad_3600
`define H2C_CFG_BAD_DESC  32'hbaad_3100
`define H2C_CFG_BAD_DM    32'hbaad_3200
`define H2C_CFG_BAD_WB    32'hbaad_3300

// Descriptor range offsets
`define H2C_CFG_OFS_DESC_CDT_CONSUMED  8'h00
`define H2C_CFG_OFS_DESC_CDT_LIMIT     8'h04
`define H2C_CFG_OFS_DESC_CNT           8'h08
`define H2C_CFG_OFS_DESC_PTR           8'h0C
`define H2C_CFG_OFS_DESC_STS           8'h18
`define H2C_CFG_OFS_DESC_INFO          8'h20

// Data mover range offsets
`define H2C_CFG_OFS_DM_CTL  8'h00
`define H2C_CFG_OFS_DM_STS  8'h04

// Write-back range offsets
`define H2C_CFG_OFS_WB_CTL      8'h00
`define H2C_CFG_OFS_WB_ADDR_LO  8'h04
`define H2C_CFG_OFS_WB_ADDR_HI  8'h08
`define H2C_CFG_OFS_WB_TO       8'h0C
`define H2C_CFG_OFS_WB_STS      8'h10
`define H2C_CFG_OFS_WB_DW       8'h14

`endif

//--- verilog/h2c_cfg_bus_pkg.sv
`default_nettype none
`include "h2c_cfg_settings.svh"

package h2c_cfg_bus_pkg;

   // Level-style request from the host, held until ack
   typedef struct packed {
      logic                         wr_req;
      logic                         rd_req;
      logic [`H2C_CFG_ADDR_W-1:0]   addr;
      logic [`H2C_CFG_DATA_W-1:0]   wdata;
   } cfg_host_req_t;

   typedef struct packed {
      logic                         ack;
      logic [`H2C_CFG_DATA_W-1:0]   rdata;
   } cfg_host_rsp_t;

   // Request as seen by one range block
   typedef struct packed {
      logic                         sel;
      logic                         wr;
      logic                         wr_rise;
      logic [7:0]                   offset;
      logic [`H2C_CFG_DATA_W-1:0]   wdata;
   } cfg_range_req_t;

   typedef struct packed {
      logic                         ack;
      logic [`H2C_CFG_DATA_W-1:0]   rdata;
   } cfg_range_rsp_t;

   typedef enum logic [1:0] {
      range_unmapped,
      range_desc,
      range_dm,
      range_wb
   } cfg_range_e;

endpackage

`default_nettype wire

//--- verilog/h2c_cfg_sts_pkg.sv
`default_nettype none
`include "h2c_cfg_settings.svh"

package h2c_cfg_sts_pkg;

   // Descriptor engine counters, pointers and event pulses
   typedef struct packed {
      logic [`H2C_CFG_DATA_W-1:0]  cdt_consumed;
      logic [`H2C_CFG_DATA_W-1:0]  cdt_limit;
      logic [`H2C_CFG_DATA_W-1:0]  desc_cnt;
      logic [`H2C_CFG_PTR_W-1:0]   wr_ptr;
      logic [`H2C_CFG_PTR_W-1:0]   rd_ptr;
      logic                        full;
      logic                        empty;
      logic                        oflow;
      logic                        ooo_error;
      logic                        unalin_error;
   } desc_sts_t;

   // One-cycle clear strobes back to the descriptor engine
   typedef struct packed {
      logic  cdt_consumed;
      logic  cdt_limit;
      logic  desc_cnt;
   } desc_clr_t;

   typedef struct packed {
      logic                          desc_cnt_en;
      logic                          pkt_cnt_en;
      logic                          desc_cdt_en;
      logic                          desc_cdt_wc_en;
      logic                          desc_cnt_wc_en;
      logic                          pkt_cnt_wc_en;
      logic [5:0]                    wc_cnt_minus1;
      logic [19:0]                   wc_tick_cnt;
      logic [3:0]                    wc_to_cnt;
      logic [`H2C_CFG_WB_ADDR_W-1:0] status_addr;
   } wb_cfg_t;

   // Error summary for the write-back engine
   typedef struct packed {
      logic  desc_error;
      logic  dm_error;
      logic  wb_error;
   } wb_err_t;

endpackage

`default_nettype wire

//--- verilog/h2c_cfg_req_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "h2c_cfg_settings.svh"

module h2c_cfg_req_decode (
   input  logic                            clk,
   input  logic                            rst_n,
   input  h2c_cfg_bus_pkg::cfg_host_req_t  host_req,
   output h2c_cfg_bus_pkg::cfg_host_rsp_t  host_rsp,
   output h2c_cfg_bus_pkg::cfg_range_req_t desc_req,
   output h2c_cfg_bus_pkg::cfg_range_req_t dm_req,
   output h2c_cfg_bus_pkg::cfg_range_req_t wb_req,
   input  h2c_cfg_bus_pkg::cfg_range_rsp_t desc_rsp,
   input  h2c_cfg_bus_pkg::cfg_range_rsp_t dm_rsp,
   input  h2c_cfg_bus_pkg::cfg_range_rsp_t wb_rsp
);

   logic                             wr_q;
   logic                             rd_q;
   logic                             wr_rise;
   h2c_cfg_bus_pkg::cfg_range_e      dec_range;
   h2c_cfg_bus_pkg::cfg_range_req_t  common_req;
   logic                             blk_ack;
   logic [`H2C_CFG_DATA_W-1:0]       blk_rdata;

   // Previous request levels, for the write edge and the ack term
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end else begin
         wr_q <= host_req.wr_req;
         rd_q <= host_req.rd_req;
      end
   end

   assign wr_rise = host_req.wr_req & ~wr_q;

   always_comb begin
      case (host_req.addr[`H2C_CFG_ADDR_W-1:8])
         `H2C_CFG_PAGE_DESC: dec_range = h2c_cfg_bus_pkg::range_desc;
         `H2C_CFG_PAGE_DM:   dec_range = h2c_cfg_bus_pkg::range_dm;
         `H2C_CFG_PAGE_WB:   dec_range = h2c_cfg_bus_pkg::range_wb;
         default:            dec_range = h2c_cfg_bus_pkg::range_unmapped;
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // Fan-out to the range blocks
   ////////////////////////////////////////////////////////////////////
   always_comb begin
      common_req.sel     = 1'b0;
      common_req.wr      = host_req.wr_req;
      common_req.wr_rise = wr_rise;
      common_req.offset  = host_req.addr[7:0];
      common_req.wdata   = host_req.wdata;

      desc_req     = common_req;
      desc_req.sel = (dec_range == h2c_cfg_bus_pkg::range_desc);
      dm_req       = common_req;
      dm_req.sel   = (dec_range == h2c_cfg_bus_pkg::range_dm);
      wb_req       = common_req;
      wb_req.sel   = (dec_range == h2c_cfg_bus_pkg::range_wb);
   end

   // Unmapped space acks on its own
   always_comb begin
      case (dec_range)
         h2c_cfg_bus_pkg::range_desc: begin
            blk_ack   = desc_rsp.ack;
            blk_rdata = desc_rsp.rdata;
         end
         h2c_cfg_bus_pkg::range_dm: begin
            blk_ack   = dm_rsp.ack;
            blk_rdata = dm_rsp.rdata;
         end
         h2c_cfg_bus_pkg::range_wb: begin
            blk_ack   = wb_rsp.ack;
            blk_rdata = wb_rsp.rdata;
         end
         default: begin
            blk_ack   = 1'b1;
            blk_rdata = `H2C_CFG_BAD_OOR;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      host_rsp.rdata <= blk_rdata;
      if (!rst_n) begin
         host_rsp.ack <= 1'b0;
      end else begin
         host_rsp.ack <= (wr_q | rd_q) & blk_ack;
      end
   end

endmodule

`default_nettype wire

//--- verilog/h2c_cfg_desc_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "h2c_cfg_settings.svh"

module h2c_cfg_desc_regs (
   input  logic                            clk,
   input  logic                            rst_n,
   input  h2c_cfg_bus_pkg::cfg_range_req_t req,
   output h2c_cfg_bus_pkg::cfg_range_rsp_t rsp,
   input  h2c_cfg_sts_pkg::desc_sts_t      desc_sts,
   output h2c_cfg_sts_pkg::desc_clr_t      desc_clr,
   output logic                            desc_err
);

   logic                        ack_wr;
   logic                        ack_rd;
   logic [`H2C_CFG_DATA_W-1:0]  rdata_q;
   logic                        wr_edge;
   logic                        wr_zero;
   // Bit order {unalin, ooo, oflow}, same as the status word
   logic [2:0]                  sticky;
   logic [2:0]                  sticky_set;
   logic [2:0]                  sticky_clr;

   assign wr_edge    = req.sel & req.wr_rise;
   assign wr_zero    = wr_edge & (req.wdata == '0);
   assign sticky_set = {desc_sts.unalin_error, desc_sts.ooo_error, desc_sts.oflow};
   assign sticky_clr = (wr_edge && req.offset == `H2C_CFG_OFS_DESC_STS) ?
                       req.wdata[2:0] : 3'b000;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_wr   <= 1'b0;
         ack_rd   <= 1'b0;
         sticky   <= 3'b000;
         desc_clr <= '0;
      end else begin
         if (req.sel && req.wr) begin
            ack_wr <= 1'b1;
         end
         ack_rd <= req.sel;
         // Event beats a clear in the same cycle
         sticky <= sticky_set | (sticky & ~sticky_clr);
         desc_clr.cdt_consumed <= wr_zero & (req.offset == `H2C_CFG_OFS_DESC_CDT_CONSUMED);
         desc_clr.cdt_limit    <= wr_zero & (req.offset == `H2C_CFG_OFS_DESC_CDT_LIMIT);
         desc_clr.desc_cnt     <= wr_zero & (req.offset == `H2C_CFG_OFS_DESC_CNT);
      end
   end

   always_ff @(posedge clk) begin
      case (req.offset)
         `H2C_CFG_OFS_DESC_CDT_CONSUMED: rdata_q <= desc_sts.cdt_consumed;
         `H2C_CFG_OFS_DESC_CDT_LIMIT:    rdata_q <= desc_sts.cdt_limit;
         `H2C_CFG_OFS_DESC_CNT:          rdata_q <= desc_sts.desc_cnt;
         `H2C_CFG_OFS_DESC_PTR:          rdata_q <= {desc_sts.rd_ptr, desc_sts.wr_ptr};
         `H2C_CFG_OFS_DESC_STS: begin
            rdata_q <= {27'd0, desc_sts.empty, desc_sts.full, sticky};
         end
         `H2C_CFG_OFS_DESC_INFO: begin
            rdata_q <= {`H2C_CFG_DESC_RAM_DEPTH, 15'd0, `H2C_CFG_DESC_TYPE};
         end
         default: rdata_q <= `H2C_CFG_BAD_DESC;
      endcase
   end

   always_comb begin
      rsp.ack   = req.wr ? ack_wr : ack_rd;
      rsp.rdata = rdata_q;
   end

   assign desc_err = |sticky;

endmodule

`default_nettype wire

//--- verilog/h2c_cfg_dm_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "h2c_cfg_settings.svh"

module h2c_cfg_dm_regs (
   input  logic                            clk,
   input  logic                            rst_n,
   input  h2c_cfg_bus_pkg::cfg_range_req_t req,
   output h2c_cfg_bus_pkg::cfg_range_rsp_t rsp,
   input  logic                            rresp_err,
   input  logic                            desc_len_err,
   output logic                            dm_err
);

   logic                        ack_wr;
   logic                        ack_rd;
   logic [`H2C_CFG_DATA_W-1:0]  ctl_q;
   logic [`H2C_CFG_DATA_W-1:0]  rdata_q;
   // {desc_len, rresp}
   logic [1:0]                  sticky;
   logic [1:0]                  sticky_clr;

   assign sticky_clr = (req.sel && req.wr_rise && req.offset == `H2C_CFG_OFS_DM_STS) ?
                       req.wdata[1:0] : 2'b00;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_wr <= 1'b0;
         ack_rd <= 1'b0;
         ctl_q  <= '0;
         sticky <= 2'b00;
      end else begin
         if (req.sel && req.wr) begin
            ack_wr <= 1'b1;
            if (req.offset == `H2C_CFG_OFS_DM_CTL) begin
               ctl_q <= req.wdata;
            end
         end
         ack_rd <= req.sel;
         sticky <= {desc_len_err, rresp_err} | (sticky & ~sticky_clr);
      end
   end

   always_ff @(posedge clk) begin
      case (req.offset)
         `H2C_CFG_OFS_DM_CTL: rdata_q <= ctl_q;
         `H2C_CFG_OFS_DM_STS: rdata_q <= {30'd0, sticky};
         default:             rdata_q <= `H2C_CFG_BAD_DM;
      endcase
   end

   always_comb begin
      rsp.ack   = req.wr ? ack_wr : ack_rd;
      rsp.rdata = rdata_q;
   end

   assign dm_err = |sticky;

endmodule

`default_nettype wire

//--- verilog/h2c_cfg_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "h2c_cfg_settings.svh"

module h2c_cfg_wb_regs (
   input  logic                            clk,
   input  logic                            rst_n,
   input  h2c_cfg_bus_pkg::cfg_range_req_t req,
   output h2c_cfg_bus_pkg::cfg_range_rsp_t rsp,
   output h2c_cfg_sts_pkg::wb_cfg_t        wb_cfg,
   input  logic                            bresp_err,
   input  logic [`H2C_CFG_DATA_W-1:0]      status_dw,
   input  logic                            desc_err,
   input  logic                            dm_err,
   output h2c_cfg_sts_pkg::wb_err_t        wb_err
);

   logic                          ack_wr;
   logic                          ack_rd;
   logic [`H2C_CFG_DATA_W-1:0]    ctl_q;
   logic [`H2C_CFG_WB_ADDR_W-1:0] status_addr_q;
   logic [19:0]                   tick_cnt_q;
   logic [3:0]                    to_cnt_q;
   logic                          bresp_sticky;
   logic                          bresp_clr;
   logic [`H2C_CFG_DATA_W-1:0]    rdata_q;

   assign bresp_clr = req.sel & req.wr_rise & (req.offset == `H2C_CFG_OFS_WB_STS) &
                      req.wdata[0];

   ////////////////////////////////////////////////////////////////////
   // Configuration registers
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_wr        <= 1'b0;
         ack_rd        <= 1'b0;
         ctl_q         <= '0;
         status_addr_q <= '0;
         tick_cnt_q    <= '0;
         to_cnt_q      <= '0;
      end else begin
         if (req.sel && req.wr) begin
            ack_wr <= 1'b1;
            case (req.offset)
               `H2C_CFG_OFS_WB_CTL:     ctl_q <= req.wdata;
               `H2C_CFG_OFS_WB_ADDR_LO: status_addr_q[31:0] <= req.wdata;
               `H2C_CFG_OFS_WB_ADDR_HI: status_addr_q[47:32] <= req.wdata[15:0];
               `H2C_CFG_OFS_WB_TO: begin
                  tick_cnt_q <= req.wdata[19:0];
                  to_cnt_q   <= req.wdata[23:20];
               end
               default: ;
            endcase
         end
         ack_rd <= req.sel;
      end
   end

   always_ff @(posedge clk) begin
      case (req.offset)
         `H2C_CFG_OFS_WB_CTL:     rdata_q <= ctl_q;
         `H2C_CFG_OFS_WB_ADDR_LO: rdata_q <= status_addr_q[31:0];
         `H2C_CFG_OFS_WB_ADDR_HI: rdata_q <= {16'd0, status_addr_q[47:32]};
         `H2C_CFG_OFS_WB_TO:      rdata_q <= {8'd0, to_cnt_q, tick_cnt_q};
         `H2C_CFG_OFS_WB_STS:     rdata_q <= {31'd0, bresp_sticky};
         `H2C_CFG_OFS_WB_DW:      rdata_q <= status_dw;
         default:                 rdata_q <= `H2C_CFG_BAD_WB;
      endcase
   end

   always_comb begin
      rsp.ack   = req.wr ? ack_wr : ack_rd;
      rsp.rdata = rdata_q;
   end

   // Control word bit fields, bits 3 and 7 reserved
   always_comb begin
      wb_cfg.desc_cnt_en    = ctl_q[0];
      wb_cfg.pkt_cnt_en     = ctl_q[1];
      wb_cfg.desc_cdt_en    = ctl_q[2];
      wb_cfg.desc_cdt_wc_en = ctl_q[4];
      wb_cfg.desc_cnt_wc_en = ctl_q[5];
      wb_cfg.pkt_cnt_wc_en  = ctl_q[6];
      wb_cfg.wc_cnt_minus1  = ctl_q[13:8];
      wb_cfg.wc_tick_cnt    = tick_cnt_q;
      wb_cfg.wc_to_cnt      = to_cnt_q;
      wb_cfg.status_addr    = status_addr_q;
   end

   ////////////////////////////////////////////////////////////////////
   // Sticky BRESP error and error summary
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bresp_sticky <= 1'b0;
         wb_err       <= '0;
      end else begin
         bresp_sticky      <= bresp_err | (bresp_sticky & ~bresp_clr);
         wb_err.desc_error <= desc_err;
         wb_err.dm_error   <= dm_err;
         wb_err.wb_error   <= bresp_sticky;
      end
   end

endmodule

`default_nettype wire

//--- verilog/h2c_cfg_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "h2c_cfg_settings.svh"

module h2c_cfg_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  h2c_cfg_bus_pkg::cfg_host_req_t  host_req,
   output h2c_cfg_bus_pkg::cfg_host_rsp_t  host_rsp,
   input  h2c_cfg_sts_pkg::desc_sts_t      desc_sts,
   output h2c_cfg_sts_pkg::desc_clr_t      desc_clr,
   input  logic                            dm_rresp_err,
   input  logic                            dm_desc_len_err,
   output h2c_cfg_sts_pkg::wb_cfg_t        wb_cfg,
   input  logic                            wb_bresp_err,
   input  logic [`H2C_CFG_DATA_W-1:0]      wb_status_dw,
   output h2c_cfg_sts_pkg::wb_err_t        wb_err
);

   h2c_cfg_bus_pkg::cfg_range_req_t  desc_req;
   h2c_cfg_bus_pkg::cfg_range_req_t  dm_req;
   h2c_cfg_bus_pkg::cfg_range_req_t  wb_req;
   h2c_cfg_bus_pkg::cfg_range_rsp_t  desc_rsp;
   h2c_cfg_bus_pkg::cfg_range_rsp_t  dm_rsp;
   h2c_cfg_bus_pkg::cfg_range_rsp_t  wb_rsp;
   logic                             desc_err;
   logic                             dm_err;

   h2c_cfg_req_decode h2c_cfg_req_decode_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .host_req (host_req),
      .host_rsp (host_rsp),
      .desc_req (desc_req),
      .dm_req   (dm_req),
      .wb_req   (wb_req),
      .desc_rsp (desc_rsp),
      .dm_rsp   (dm_rsp),
      .wb_rsp   (wb_rsp)
   );

   h2c_cfg_desc_regs h2c_cfg_desc_regs_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (desc_req),
      .rsp      (desc_rsp),
      .desc_sts (desc_sts),
      .desc_clr (desc_clr),
      .desc_err (desc_err)
   );

   h2c_cfg_dm_regs h2c_cfg_dm_regs_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (dm_req),
      .rsp          (dm_rsp),
      .rresp_err    (dm_rresp_err),
      .desc_len_err (dm_desc_len_err),
      .dm_err       (dm_err)
   );

   // Write-back block also collects the other ranges' errors
   h2c_cfg_wb_regs h2c_cfg_wb_regs_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (wb_req),
      .rsp       (wb_rsp),
      .wb_cfg    (wb_cfg),
      .bresp_err (wb_bresp_err),
      .status_dw (wb_status_dw),
      .desc_err  (desc_err),
      .dm_err    (dm_err),
      .wb_err    (wb_err)
   );

endmodule

`default_nettype wire

//--- dv/h2c_cfg_checker.sv
`timescale 1ns/1ns
`default_nettype none

module h2c_cfg_checker (
   input  logic                            clk,
   input  logic                            rst_n,
   input  h2c_cfg_bus_pkg::cfg_host_req_t  host_req,
   input  h2c_cfg_bus_pkg::cfg_host_rsp_t  host_rsp,
   input  h2c_cfg_sts_pkg::desc_clr_t      desc_clr
);

   int ack_fails    = 0;
   int pulse_fails  = 0;
   int onehot_fails = 0;

   // Ack is registered from the request level seen one edge before its own edge
   ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
      host_rsp.ack |-> $past(host_req.wr_req | host_req.rd_req, 2))
   else begin
      ack_fails++;
      $error("host ack raised without a preceding request");
   end

   clr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      (desc_clr != 3'b000) |=> (desc_clr == 3'b000))
   else begin
      pulse_fails++;
      $error("desc_clr strobe held longer than one cycle");
   end

   clr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(desc_clr))
   else begin
      onehot_fails++;
      $error("more than one desc_clr strobe high");
   end

endmodule

bind h2c_cfg_top h2c_cfg_checker checker_i (
   .clk      (clk),
   .rst_n    (rst_n),
   .host_req (host_req),
   .host_rsp (host_rsp),
   .desc_clr (desc_clr)
);

`default_nettype wire

//--- dv/h2c_cfg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module h2c_cfg_tb;

   typedef enum logic [1:0] {
      op_write,
      op_read,
      op_inject
   } op_e;

   // Event mask {bresp, desc_len, rresp, unalin, ooo, oflow}
   typedef struct packed {
      op_e          op;
      logic [15:0]  addr;
      logic [31:0]  wdata;
      logic [5:0]   mask;
      logic [31:0]  exp;
   } row_t;

   logic                            clk;
   logic                            rst_n;
   h2c_cfg_bus_pkg::cfg_host_req_t  host_req;
   h2c_cfg_bus_pkg::cfg_host_rsp_t  host_rsp;
   h2c_cfg_sts_pkg::desc_sts_t      desc_sts;
   h2c_cfg_sts_pkg::desc_clr_t      desc_clr;
   logic                            dm_rresp_err;
   logic                            dm_desc_len_err;
   h2c_cfg_sts_pkg::wb_cfg_t        wb_cfg;
   logic                            wb_bresp_err;
   logic [31:0]                     wb_status_dw;
   h2c_cfg_sts_pkg::wb_err_t        wb_err;

   integer  seed = 32'hc1cf_26ff;
   row_t    rows[$];
   logic    table_ready = 1'b0;
   int      cnt_consumed = 0;
   int      cnt_limit = 0;
   int      cnt_desc = 0;

   // Register model updated while the table is built
   logic [31:0]  m_wb_ctl = '0;
   logic [31:0]  m_wb_lo = '0;
   logic [15:0]  m_wb_hi = '0;
   logic [23:0]  m_wb_to = '0;
   logic [31:0]  m_dm_ctl = '0;
   logic [2:0]   m_desc_sticky = '0;
   logic [1:0]   m_dm_sticky = '0;
   logic         m_wb_sticky = 1'b0;

   h2c_cfg_top h2c_cfg_top_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .host_req        (host_req),
      .host_rsp        (host_rsp),
      .desc_sts        (desc_sts),
      .desc_clr        (desc_clr),
      .dm_rresp_err    (dm_rresp_err),
      .dm_desc_len_err (dm_desc_len_err),
      .wb_cfg          (wb_cfg),
      .wb_bresp_err    (wb_bresp_err),
      .wb_status_dw    (wb_status_dw),
      .wb_err          (wb_err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(negedge clk) begin
      if (rst_n) begin
         if (desc_clr.cdt_consumed) cnt_consumed++;
         if (desc_clr.cdt_limit) cnt_limit++;
         if (desc_clr.desc_cnt) cnt_desc++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Model of the register map
   //////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] model_read(input logic [15:0] addr);
      logic [31:0] val;
      case (addr[15:8])
         8'h01: case (addr[7:0])
            8'h00:   val = desc_sts.cdt_consumed;
            8'h04:   val = desc_sts.cdt_limit;
            8'h08:   val = desc_sts.desc_cnt;
            8'h0c:   val = {desc_sts.rd_ptr, desc_sts.wr_ptr};
            8'h18:   val = {27'd0, desc_sts.empty, desc_sts.full, m_desc_sticky};
            8'h20:   val = {16'd64, 15'd0, 1'b0};
            default: val = 32'hbaad_3100;
         endcase
         8'h02: case (addr[7:0])
            8'h00:   val = m_dm_ctl;
            8'h04:   val = {30'd0, m_dm_sticky};
            default: val = 32'hbaad_3200;
         endcase
         8'h03: case (addr[7:0])
            8'h00:   val = m_wb_ctl;
            8'h04:   val = m_wb_lo;
            8'h08:   val = {16'd0, m_wb_hi};
            8'h0c:   val = {8'd0, m_wb_to};
            8'h10:   val = {31'd0, m_wb_sticky};
            8'h14:   val = wb_status_dw;
            default: val = 32'hbaad_3300;
         endcase
         default: val = 32'hbaad_3600;
      endcase
      return val;
   endfunction

   function automatic void model_write(input logic [15:0] addr, input logic [31:0] wdata);
      case (addr[15:8])
         8'h01: begin
            if (addr[7:0] == 8'h18) m_desc_sticky = m_desc_sticky & ~wdata[2:0];
         end
         8'h02: begin
            if (addr[7:0] == 8'h00) m_dm_ctl = wdata;
            if (addr[7:0] == 8'h04) m_dm_sticky = m_dm_sticky & ~wdata[1:0];
         end
         8'h03: begin
            if (addr[7:0] == 8'h00) m_wb_ctl = wdata;
            if (addr[7:0] == 8'h04) m_wb_lo = wdata;
            if (addr[7:0] == 8'h08) m_wb_hi = wdata[15:0];
            if (addr[7:0] == 8'h0c) m_wb_to = wdata[23:0];
            if (addr[7:0] == 8'h10) m_wb_sticky = m_wb_sticky & ~wdata[0];
         end
         default: ;
      endcase
   endfunction

   function automatic logic [2:0] model_err();
      return {|m_desc_sticky, |m_dm_sticky, m_wb_sticky};
   endfunction

   // Strobe order {cdt_consumed, cdt_limit, desc_cnt}
   function automatic logic [2:0] clear_expected(input logic [15:0] addr,
                                                 input logic [31:0] wdata);
      logic [2:0] clr;
      clr = 3'b000;
      if (addr[15:8] == 8'h01 && wdata == 32'd0) begin
         if (addr[7:0] == 8'h00) clr = 3'b100;
         if (addr[7:0] == 8'h04) clr = 3'b010;
         if (addr[7:0] == 8'h08) clr = 3'b001;
      end
      return clr;
   endfunction

   task automatic add_row(input op_e op, input logic [15:0] addr, input logic [31:0] wdata,
                          input logic [5:0] mask, input logic [31:0] exp);
      row_t row;
      row.op = op;
      row.addr = addr;
      row.wdata = wdata;
      row.mask = mask;
      row.exp = exp;
      rows.push_back(row);
   endtask

   task automatic add_write(input logic [15:0] addr, input logic [31:0] wdata);
      model_write(addr, wdata);
      add_row(op_write, addr, wdata, 6'd0, {29'd0, model_err()});
   endtask

   task automatic add_read(input logic [15:0] addr);
      add_row(op_read, addr, 32'd0, 6'd0, model_read(addr));
   endtask

   task automatic add_event(input logic [5:0] mask);
      m_desc_sticky = m_desc_sticky | mask[2:0];
      m_dm_sticky = m_dm_sticky | mask[4:3];
      m_wb_sticky = m_wb_sticky | mask[5];
      add_row(op_inject, 16'd0, 32'd0, mask, {29'd0, model_err()});
   endtask

   task automatic build_table();
      // Write-back configuration
      add_write(16'h0300, 32'h0000_2a75);
      add_read(16'h0300);
      add_write(16'h0304, 32'hdead_beef);
      add_write(16'h0308, 32'habcd_1234);
      add_read(16'h0304);
      add_read(16'h0308);
      add_write(16'h030c, 32'h0012_3456);
      add_read(16'h030c);
      add_read(16'h0314);
      // Descriptor readback
      add_read(16'h0100);
      add_read(16'h0104);
      add_read(16'h0108);
      add_read(16'h010c);
      add_read(16'h0118);
      add_read(16'h0120);
      // Clear strobes then one nonzero write
      add_write(16'h0100, 32'd0);
      add_write(16'h0104, 32'd0);
      add_write(16'h0108, 32'd0);
      add_write(16'h0104, 32'h0000_0005);
      // Sticky errors in each range
      add_event(6'b000001);
      add_read(16'h0118);
      add_event(6'b000100);
      add_read(16'h0118);
      add_event(6'b000010);
      add_read(16'h0118);
      add_write(16'h0118, 32'h0000_0001);
      add_read(16'h0118);
      add_write(16'h0118, 32'h0000_0004);
      add_read(16'h0118);
      add_write(16'h0118, 32'h0000_0002);
      add_read(16'h0118);
      add_event(6'b001000);
      add_read(16'h0204);
      add_event(6'b010000);
      add_write(16'h0204, 32'h0000_0001);
      add_read(16'h0204);
      add_write(16'h0204, 32'h0000_0002);
      add_read(16'h0204);
      add_event(6'b100000);
      add_read(16'h0310);
      add_write(16'h0310, 32'h0000_0001);
      add_read(16'h0310);
      // Data mover control, unknown offsets and unmapped space
      add_write(16'h0200, 32'h5a5a_0f0f);
      add_read(16'h0200);
      add_read(16'h0150);
      add_read(16'h0260);
      add_read(16'h0380);
      add_read(16'h0000);
      add_read(16'h0400);
      add_read(16'h0700);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checks and host transactions
   //////////////////////////////////////////////////////////////////////
   task automatic check(input string name, input logic [95:0] exp, input logic [95:0] act);
      if (act !== exp) begin
         $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
         $display("Verification failed");
         $fatal(1, "Value check on %s", name);
      end
   endtask

   task automatic wait_ack(input logic level);
      int cycles;
      cycles = 0;
      while (host_rsp.ack !== level && cycles < 8) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (host_rsp.ack !== level) begin
         $display("Host ack did not go to %0b within 8 cycles at %0t ns", level, $time);
         $display("Verification failed");
         $fatal(1, "Ack timeout");
      end
   endtask

   task automatic host_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      host_req.wr_req = wr;
      host_req.rd_req = ~wr;
      host_req.addr = addr;
      host_req.wdata = wdata;
      wait_ack(1'b1);
      rdata = host_rsp.rdata;
      host_req.wr_req = 1'b0;
      host_req.rd_req = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic apply_row(input row_t row);
      logic [31:0] rdata;
      logic [2:0]  exp_clr;
      int          c0;
      int          l0;
      int          n0;
      case (row.op)
         op_read: begin
            host_xfer(1'b0, row.addr, 32'd0, rdata);
            check($sformatf("host_rsp.rdata (addr 0x%h)", row.addr), 96'(row.exp), 96'(rdata));
         end
         op_write: begin
            exp_clr = clear_expected(row.addr, row.wdata);
            c0 = cnt_consumed;
            l0 = cnt_limit;
            n0 = cnt_desc;
            host_xfer(1'b1, row.addr, row.wdata, rdata);
            check($sformatf("desc_clr pulse count (addr 0x%h)", row.addr),
                  96'({7'd0, exp_clr[2], 7'd0, exp_clr[1], 7'd0, exp_clr[0]}),
                  96'({8'(cnt_consumed - c0), 8'(cnt_limit - l0), 8'(cnt_desc - n0)}));
            check("wb_err", 96'(row.exp[2:0]), 96'(wb_err));
         end
         op_inject: begin
            desc_sts.oflow = row.mask[0];
            desc_sts.ooo_error = row.mask[1];
            desc_sts.unalin_error = row.mask[2];
            dm_rresp_err = row.mask[3];
            dm_desc_len_err = row.mask[4];
            wb_bresp_err = row.mask[5];
            @(posedge clk);
            #1;
            desc_sts.oflow = 1'b0;
            desc_sts.ooo_error = 1'b0;
            desc_sts.unalin_error = 1'b0;
            dm_rresp_err = 1'b0;
            dm_desc_len_err = 1'b0;
            wb_bresp_err = 1'b0;
            // Sticky bit then summary register
            repeat (3) @(posedge clk);
            #1;
            check("wb_err", 96'(row.exp[2:0]), 96'(wb_err));
         end
         default: ;
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      logic [31:0]               rnd;
      h2c_cfg_sts_pkg::wb_cfg_t  exp_cfg;
      int                        assert_fails;
      rst_n = 1'b0;
      host_req = '0;
      desc_sts = '0;
      dm_rresp_err = 1'b0;
      dm_desc_len_err = 1'b0;
      wb_bresp_err = 1'b0;
      wb_status_dw = '0;
      // Engine status held fixed for the whole run
      rnd = $random(seed);
      desc_sts.cdt_consumed = rnd;
      rnd = $random(seed);
      desc_sts.cdt_limit = rnd;
      rnd = $random(seed);
      desc_sts.desc_cnt = rnd;
      rnd = $random(seed);
      desc_sts.wr_ptr = rnd[15:0];
      desc_sts.rd_ptr = rnd[31:16];
      rnd = $random(seed);
      desc_sts.full = rnd[0];
      desc_sts.empty = rnd[1];
      rnd = $random(seed);
      wb_status_dw = rnd;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < rows.size(); i++) begin
         apply_row(rows[i]);
      end
      exp_cfg.desc_cnt_en = m_wb_ctl[0];
      exp_cfg.pkt_cnt_en = m_wb_ctl[1];
      exp_cfg.desc_cdt_en = m_wb_ctl[2];
      exp_cfg.desc_cdt_wc_en = m_wb_ctl[4];
      exp_cfg.desc_cnt_wc_en = m_wb_ctl[5];
      exp_cfg.pkt_cnt_wc_en = m_wb_ctl[6];
      exp_cfg.wc_cnt_minus1 = m_wb_ctl[13:8];
      exp_cfg.wc_tick_cnt = m_wb_to[19:0];
      exp_cfg.wc_to_cnt = m_wb_to[23:20];
      exp_cfg.status_addr = {m_wb_hi, m_wb_lo};
      check("wb_cfg", 96'(exp_cfg), 96'(wb_cfg));
      check("wb_err", 96'(model_err()), 96'(wb_err));
      assert_fails = h2c_cfg_top_i.checker_i.ack_fails + h2c_cfg_top_i.checker_i.pulse_fails +
                     h2c_cfg_top_i.checker_i.onehot_fails;
      if (assert_fails == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("The bound checker reported %0d assertion failures", assert_fails);
         $display("Verification failed");
         $fatal(1, "Assertion failures");
      end
   end

   // Watchdog sized from the table length
   initial begin
      wait (table_ready);
      repeat (rows.size() * 20 + 100) @(posedge clk);
      $display("Timeout: the stimulus table did not finish in time");
      $display("Verification failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/h2c_cfg_bus_pkg.sv
verilog/h2c_cfg_sts_pkg.sv
verilog/h2c_cfg_req_decode.sv
verilog/h2c_cfg_desc_regs.sv
verilog/h2c_cfg_dm_regs.sv
verilog/h2c_cfg_wb_regs.sv
verilog/h2c_cfg_top.sv
dv/h2c_cfg_checker.sv
dv/h2c_cfg_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := h2c_cfg_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
